// File: biu_pkg.sv
/* Memory access front-end types */

`default_nettype none

package biu_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Virtual address width of the core
  localparam int XLEN = 32;

  // Physical address width on the bus side
  localparam int PLEN = 34;

  // Number of physical memory attribute regions
  localparam int NUM_REGIONS = 4;

  typedef logic [XLEN-1:0]                vadr_t;
  typedef logic [PLEN-1:0]                padr_t;
  typedef logic [3:0]                     byte_en_t;
  typedef logic [$clog2(NUM_REGIONS)-1:0] region_idx_t;

  //////////////////////////////////////////////////
  // Access size and request types
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    BYTE  = 2'b00,
    HWORD = 2'b01,
    WORD  = 2'b10,
    DWORD = 2'b11
  } biu_size_t;

  // Request as issued by the CPU
  typedef struct packed {
    vadr_t     adr;
    biu_size_t size;
    logic      lock;
    logic      we;
    logic      cm_clean;
    logic      cm_invalidate;
  } cpu_req_t;

  // Same request after translation
  typedef struct packed {
    padr_t     adr;
    biu_size_t size;
    logic      lock;
    logic      we;
    logic      cm_clean;
    logic      cm_invalidate;
  } phys_req_t;

  //////////////////////////////////////////////////
  // PMA types
  //////////////////////////////////////////////////

  // Limit is inclusive
  typedef struct packed {
    logic  valid;
    padr_t base;
    padr_t limit;
    logic  readable;
    logic  writable;
    logic  cacheable;
  } pma_region_t;

  typedef struct packed {
    logic hit;
    logic readable;
    logic writable;
    logic cacheable;
  } pma_attr_t;

  //////////////////////////////////////////////////
  // Bus and fault types
  //////////////////////////////////////////////////

  // Word aligned address with byte lanes
  typedef struct packed {
    padr_t    adr;
    byte_en_t be;
    logic     we;
    logic     lock;
    logic     cacheable;
    logic     cm_clean;
    logic     cm_invalidate;
  } bus_req_t;

  typedef enum logic [1:0] {
    FLT_NONE       = 2'b00,
    FLT_MISALIGNED = 2'b01,
    FLT_ACCESS     = 2'b10
  } fault_cause_t;

  typedef struct packed {
    fault_cause_t cause;
    padr_t        adr;
  } fault_t;

endpackage

`default_nettype wire

// File: mem_xlate_stage.sv
/* No-MMU address translation */

`timescale 1ns/10ps
`default_nettype none

module mem_xlate_stage
  import biu_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  input  wire logic      stall_i,
  input  wire logic      flush_i,
  input  wire logic      req_i,
  input  wire cpu_req_t  cpu_req_i,
  output      logic      req_o,
  output      phys_req_t phys_o
);

  //////////////////////////////////////////////////
  // Address mapping
  //////////////////////////////////////////////////

  // Identity map, upper physical bits are zero
  padr_t padr;

  assign padr = {{(PLEN-XLEN){1'b0}}, cpu_req_i.adr};

  //////////////////////////////////////////////////
  // Request strobe
  //////////////////////////////////////////////////

  // Flush drops the request in this stage
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      req_o <= 1'b0;
    end
    else if (flush_i)
    begin
      req_o <= 1'b0;
    end
    else if (!stall_i)
    begin
      req_o <= req_i;
    end
  end

  //////////////////////////////////////////////////
  // Request fields
  //////////////////////////////////////////////////

  // A TLB lookup would replace this register later
  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
    begin
      phys_o.adr           <= padr;
      phys_o.size          <= cpu_req_i.size;
      phys_o.lock          <= cpu_req_i.lock;
      phys_o.we            <= cpu_req_i.we;
      phys_o.cm_clean      <= cpu_req_i.cm_clean;
      phys_o.cm_invalidate <= cpu_req_i.cm_invalidate;
    end
  end

endmodule

`default_nettype wire

// File: pma_regs.sv
/* PMA region configuration */

`timescale 1ns/10ps
`default_nettype none

module pma_regs
  import biu_pkg::*;
(
  input  wire logic                          clk_i,
  input  wire logic                          rst_ni,
  input  wire logic                          cfg_we_i,
  input  wire region_idx_t                   cfg_idx_i,
  input  wire pma_region_t                   cfg_region_i,
  output      pma_region_t [NUM_REGIONS-1:0] regions_o
);

  //////////////////////////////////////////////////
  // Region storage
  //////////////////////////////////////////////////

  // Valid bits, cleared so every access faults after reset
  logic [NUM_REGIONS-1:0] valid_q;

  // Address ranges
  padr_t base_q  [NUM_REGIONS];
  padr_t limit_q [NUM_REGIONS];

  // Attribute bits per region
  logic [NUM_REGIONS-1:0] rd_q;
  logic [NUM_REGIONS-1:0] wr_q;
  logic [NUM_REGIONS-1:0] cache_q;

  //////////////////////////////////////////////////
  // Config writes
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      valid_q <= '0;
    end
    else if (cfg_we_i)
    begin
      valid_q[cfg_idx_i] <= cfg_region_i.valid;
    end
  end

  // Range and attributes follow the same strobe
  always_ff @(posedge clk_i)
  begin
    if (cfg_we_i)
    begin
      base_q[cfg_idx_i]  <= cfg_region_i.base;
      limit_q[cfg_idx_i] <= cfg_region_i.limit;
      rd_q[cfg_idx_i]    <= cfg_region_i.readable;
      wr_q[cfg_idx_i]    <= cfg_region_i.writable;
      cache_q[cfg_idx_i] <= cfg_region_i.cacheable;
    end
  end

  //////////////////////////////////////////////////
  // Read side
  //////////////////////////////////////////////////

  // Descriptors are visible without delay
  always_comb
  begin
    for (int i = 0; i < NUM_REGIONS; i++)
    begin
      regions_o[i].valid     = valid_q[i];
      regions_o[i].base      = base_q[i];
      regions_o[i].limit     = limit_q[i];
      regions_o[i].readable  = rd_q[i];
      regions_o[i].writable  = wr_q[i];
      regions_o[i].cacheable = cache_q[i];
    end
  end

endmodule

`default_nettype wire

// File: pma_check.sv
/* PMA region matcher */

`timescale 1ns/10ps
`default_nettype none

module pma_check
  import biu_pkg::*;
(
  input  wire padr_t                         adr_i,
  input  wire pma_region_t [NUM_REGIONS-1:0] regions_i,
  output      pma_attr_t                     attr_o
);

  //////////////////////////////////////////////////
  // Range compare
  //////////////////////////////////////////////////

  // One match bit per region, all regions in parallel
  logic [NUM_REGIONS-1:0] match;

  always_comb
  begin
    for (int i = 0; i < NUM_REGIONS; i++)
    begin
      // Base and limit are both inclusive
      match[i] = regions_i[i].valid &&
                 (adr_i >= regions_i[i].base) &&
                 (adr_i <= regions_i[i].limit);
    end
  end

  //////////////////////////////////////////////////
  // Priority select
  //////////////////////////////////////////////////

  // Index of the winning region
  region_idx_t sel_idx;

  // Walk downward so the lowest index wins
  always_comb
  begin
    sel_idx = '0;
    for (int i = NUM_REGIONS - 1; i >= 0; i--)
    begin
      if (match[i])
      begin
        sel_idx = region_idx_t'(i);
      end
    end
  end

  //////////////////////////////////////////////////
  // Attribute output
  //////////////////////////////////////////////////

  // Without a hit all permissions read as zero
  always_comb
  begin
    attr_o.hit       = |match;
    attr_o.readable  = 1'b0;
    attr_o.writable  = 1'b0;
    attr_o.cacheable = 1'b0;
    if (|match)
    begin
      attr_o.readable  = regions_i[sel_idx].readable;
      attr_o.writable  = regions_i[sel_idx].writable;
      attr_o.cacheable = regions_i[sel_idx].cacheable;
    end
  end

endmodule

`default_nettype wire

// File: biu_issue.sv
/* Bus issue and fault stage */

`timescale 1ns/10ps
`default_nettype none

module biu_issue
  import biu_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  input  wire logic      stall_i,
  input  wire logic      flush_i,
  input  wire logic      req_i,
  input  wire phys_req_t phys_i,
  input  wire pma_attr_t attr_i,
  output      logic      bus_req_o,
  output      bus_req_t  bus_o,
  output      logic      fault_o,
  output      fault_t    fault_info_o
);

  //////////////////////////////////////////////////
  // Request classification
  //////////////////////////////////////////////////

  logic         cm_op;
  logic         misaligned;
  logic         perm_fail;
  byte_en_t     be_base;
  fault_cause_t cause;
  bus_req_t     bus_d;

  // Cache maintenance skips alignment and permissions
  assign cm_op = phys_i.cm_clean | phys_i.cm_invalidate;

  // Alignment check and unshifted lane mask
  always_comb
  begin
    case (phys_i.size)
      BYTE:
      begin
        misaligned = 1'b0;
        be_base    = 4'b0001;
      end
      HWORD:
      begin
        misaligned = phys_i.adr[0];
        be_base    = 4'b0011;
      end
      WORD:
      begin
        misaligned = |phys_i.adr[1:0];
        be_base    = 4'b1111;
      end
      default:
      begin
        misaligned = 1'b1;
        be_base    = 4'b0000;
      end
    endcase
  end

  // Missing region or missing read/write right
  assign perm_fail = !attr_i.hit ||
                     ( phys_i.we && !attr_i.writable) ||
                     (!phys_i.we && !attr_i.readable);

  // Misalignment wins over an access fault
  always_comb
  begin
    if (cm_op)
      cause = attr_i.hit ? FLT_NONE : FLT_ACCESS;
    else if (misaligned)
      cause = FLT_MISALIGNED;
    else if (perm_fail)
      cause = FLT_ACCESS;
    else
      cause = FLT_NONE;
  end

  //////////////////////////////////////////////////
  // Bus request build
  //////////////////////////////////////////////////

  always_comb
  begin
    bus_d.adr           = {phys_i.adr[PLEN-1:2], 2'b00};
    bus_d.be            = cm_op ? '0 : byte_en_t'(be_base << phys_i.adr[1:0]);
    bus_d.we            = phys_i.we;
    bus_d.lock          = phys_i.lock;
    bus_d.cacheable     = attr_i.cacheable;
    bus_d.cm_clean      = phys_i.cm_clean;
    bus_d.cm_invalidate = phys_i.cm_invalidate;
  end

  //////////////////////////////////////////////////
  // Output registers
  //////////////////////////////////////////////////

  // Exactly one strobe per request and none after a flush
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      bus_req_o <= 1'b0;
      fault_o   <= 1'b0;
    end
    else if (flush_i)
    begin
      bus_req_o <= 1'b0;
      fault_o   <= 1'b0;
    end
    else if (!stall_i)
    begin
      bus_req_o <= req_i && (cause == FLT_NONE);
      fault_o   <= req_i && (cause != FLT_NONE);
    end
  end

  // Fault address keeps the raw physical address
  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
    begin
      bus_o              <= bus_d;
      fault_info_o.cause <= cause;
      fault_info_o.adr   <= phys_i.adr;
    end
  end

endmodule

`default_nettype wire

// File: mem_access_top.sv
/* Memory access front-end top */

`timescale 1ns/10ps
`default_nettype none

module mem_access_top
  import biu_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_ni,
  input  wire logic        stall_i,
  input  wire logic        flush_i,
  input  wire logic        req_i,
  input  wire logic        cfg_we_i,
  input  wire cpu_req_t    cpu_req_i,
  input  wire region_idx_t cfg_idx_i,
  input  wire pma_region_t cfg_region_i,
  output      logic        bus_req_o,
  output      bus_req_t    bus_o,
  output      logic        fault_o,
  output      fault_t      fault_info_o
);

  //////////////////////////////////////////////////
  // Pipeline wires
  //////////////////////////////////////////////////

  // Translated request between the two stages
  logic      xl_req;
  phys_req_t xl_phys;

  // Region table and match result
  pma_region_t [NUM_REGIONS-1:0] regions;
  pma_attr_t                     attr;

  //////////////////////////////////////////////////
  // Stage 1, translation
  //////////////////////////////////////////////////

  mem_xlate_stage u_xlate (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .stall_i   (stall_i),
    .flush_i   (flush_i),
    .req_i     (req_i),
    .cpu_req_i (cpu_req_i),
    .req_o     (xl_req),
    .phys_o    (xl_phys)
  );

  // Region descriptors, written by software
  pma_regs u_pma_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cfg_we_i     (cfg_we_i),
    .cfg_idx_i    (cfg_idx_i),
    .cfg_region_i (cfg_region_i),
    .regions_o    (regions)
  );

  // Attribute lookup on the translated address
  pma_check u_pma_check (
    .adr_i     (xl_phys.adr),
    .regions_i (regions),
    .attr_o    (attr)
  );

  //////////////////////////////////////////////////
  // Stage 2, issue
  //////////////////////////////////////////////////

  biu_issue u_issue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .stall_i      (stall_i),
    .flush_i      (flush_i),
    .req_i        (xl_req),
    .phys_i       (xl_phys),
    .attr_i       (attr),
    .bus_req_o    (bus_req_o),
    .bus_o        (bus_o),
    .fault_o      (fault_o),
    .fault_info_o (fault_info_o)
  );

endmodule

`default_nettype wire

// File: tb_checks.svh
/* Testbench compare helpers */

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

//////////////////////////////////////////////////
// Error count and random source
//////////////////////////////////////////////////

// Failed checks so far
int err_count = 0;

// Fibonacci LFSR state, x^16 + x^14 + x^13 + x^11 + 1
logic [15:0] lfsr_q = 16'd51;

// One LFSR step, returns the new bit
function automatic logic lfsr_bit();
  logic fb;
  fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
  lfsr_q = {lfsr_q[14:0], fb};
  return fb;
endfunction

// Collect n bits, one LFSR step per bit
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] val;
  val = '0;
  for (int i = 0; i < n; i++)
  begin
    val = {val[30:0], lfsr_bit()};
  end
  return val;
endfunction

//////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////

// Whole bus request, payload only
task automatic compare_bus(input bus_req_t got, input bus_req_t exp);
  if (got !== exp)
  begin
    err_count++;
    $display("Mismatch bus_o at %0t: got %h expected %h", $time, got, exp);
  end
endtask

// Fault cause and address
task automatic compare_fault(input fault_t got, input fault_t exp);
  if (got !== exp)
  begin
    err_count++;
    $display("Mismatch fault_info_o at %0t: got %h expected %h", $time, got, exp);
  end
endtask

// Strobes and single flags
task automatic compare_bit(input string name, input logic got, input logic exp);
  if (got !== exp)
  begin
    err_count++;
    $display("Mismatch %s at %0t: got %h expected %h", name, $time, got, exp);
  end
endtask

`endif

// File: tb_mem_access.sv
/* Memory access front-end testbench */

`timescale 1ns/10ps
`default_nettype none

module tb_mem_access
  import biu_pkg::*;
();

  //////////////////////////////////////////////////
  // DUT signals
  //////////////////////////////////////////////////

  logic        clk_i;
  logic        rst_ni;
  logic        stall_i;
  logic        flush_i;
  logic        req_i;
  logic        cfg_we_i;
  cpu_req_t    cpu_req_i;
  region_idx_t cfg_idx_i;
  pma_region_t cfg_region_i;
  logic        bus_req_o;
  bus_req_t    bus_o;
  logic        fault_o;
  fault_t      fault_info_o;

  // Run limit in clock cycles
  localparam int MAX_CYCLES = 3000;
  int cycles = 0;

  // Testbench copy of the region table
  pma_region_t ref_regions [NUM_REGIONS];

  `include "tb_checks.svh"

  mem_access_top UUT (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .stall_i      (stall_i),
    .flush_i      (flush_i),
    .req_i        (req_i),
    .cfg_we_i     (cfg_we_i),
    .cpu_req_i    (cpu_req_i),
    .cfg_idx_i    (cfg_idx_i),
    .cfg_region_i (cfg_region_i),
    .bus_req_o    (bus_req_o),
    .bus_o        (bus_o),
    .fault_o      (fault_o),
    .fault_info_o (fault_info_o)
  );

  // 10 ns clock
  always #5 clk_i = ~clk_i;

  always @(posedge clk_i)
  begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("Timeout after %0d cycles, test sequence did not finish", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Expected outcome of one request from the access rules
  function automatic void expect_result(input cpu_req_t r, output logic is_fault,
                                        output bus_req_t b, output fault_t f);
    padr_t    pa;
    logic     hit;
    logic     rd;
    logic     wr;
    logic     ca;
    logic     mis;
    byte_en_t lanes;
    pa  = padr_t'(r.adr);
    hit = 1'b0;
    rd  = 1'b0;
    wr  = 1'b0;
    ca  = 1'b0;
    // First matching region in index order
    for (int k = 0; k < NUM_REGIONS; k++)
    begin
      if (!hit && ref_regions[k].valid && pa >= ref_regions[k].base &&
          pa <= ref_regions[k].limit)
      begin
        hit = 1'b1;
        rd  = ref_regions[k].readable;
        wr  = ref_regions[k].writable;
        ca  = ref_regions[k].cacheable;
      end
    end
    case (r.size)
      BYTE:
      begin
        mis   = 1'b0;
        lanes = 4'h1;
      end
      HWORD:
      begin
        mis   = pa[0];
        lanes = 4'h3;
      end
      WORD:
      begin
        mis   = pa[1:0] != 0;
        lanes = 4'hF;
      end
      default:
      begin
        mis   = 1'b1;
        lanes = 4'h0;
      end
    endcase
    lanes   = lanes << pa[1:0];
    f.adr   = pa;
    f.cause = FLT_NONE;
    if (r.cm_clean || r.cm_invalidate)
    begin
      if (!hit)
        f.cause = FLT_ACCESS;
      lanes = 4'h0;
    end
    else if (mis)
      f.cause = FLT_MISALIGNED;
    else if (!hit || (r.we && !wr) || (!r.we && !rd))
      f.cause = FLT_ACCESS;
    b.adr           = pa & ~padr_t'(3);
    b.be            = lanes;
    b.we            = r.we;
    b.lock          = r.lock;
    b.cacheable     = ca;
    b.cm_clean      = r.cm_clean;
    b.cm_invalidate = r.cm_invalidate;
    is_fault        = f.cause != FLT_NONE;
  endfunction

  //////////////////////////////////////////////////
  // Drive and check helpers
  //////////////////////////////////////////////////

  function automatic cpu_req_t make_req(input vadr_t adr, input biu_size_t size,
                                        input logic we, input logic lock,
                                        input logic cl, input logic inv);
    cpu_req_t r;
    r.adr           = adr;
    r.size          = size;
    r.lock          = lock;
    r.we            = we;
    r.cm_clean      = cl;
    r.cm_invalidate = inv;
    return r;
  endfunction

  // Strobes plus the payload of the one that should fire
  task automatic check_result(input cpu_req_t r);
    logic     is_fault;
    bus_req_t b;
    fault_t   f;
    expect_result(r, is_fault, b, f);
    compare_bit("bus_req_o", bus_req_o, !is_fault);
    compare_bit("fault_o", fault_o, is_fault);
    if (is_fault)
      compare_fault(fault_info_o, f);
    else
      compare_bus(bus_o, b);
  endtask

  task automatic check_idle();
    compare_bit("bus_req_o", bus_req_o, 1'b0);
    compare_bit("fault_o", fault_o, 1'b0);
  endtask

  // One request with its result two edges later
  task automatic send_req(input cpu_req_t r);
    @(negedge clk_i);
    req_i     = 1'b1;
    cpu_req_i = r;
    @(negedge clk_i);
    req_i = 1'b0;
    @(negedge clk_i);
    check_result(r);
  endtask

  task automatic write_region(input region_idx_t idx, input pma_region_t rgn);
    @(negedge clk_i);
    cfg_we_i     = 1'b1;
    cfg_idx_i    = idx;
    cfg_region_i = rgn;
    @(negedge clk_i);
    cfg_we_i         = 1'b0;
    ref_regions[idx] = rgn;
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic test_reset_state();
    check_idle();
    send_req(make_req(32'h0000_0100, WORD, 1'b0, 1'b0, 1'b0, 1'b0));
  endtask

  // Region 0 read-only and cacheable and region 1 write-only with overlap from 0x1800
  task automatic test_random_access();
    pma_region_t rgn;
    logic [31:0] adr;
    logic [31:0] pick;
    logic [31:0] flags;
    biu_size_t   size;
    rgn = '{valid: 1'b1, base: 34'h1000, limit: 34'h1FFF,
            readable: 1'b1, writable: 1'b0, cacheable: 1'b1};
    write_region(2'd0, rgn);
    rgn = '{valid: 1'b1, base: 34'h1800, limit: 34'h2FFF,
            readable: 1'b0, writable: 1'b1, cacheable: 1'b0};
    write_region(2'd1, rgn);
    for (int n = 0; n < 16; n++)
    begin
      adr   = 32'h1000 + rand_bits(13);
      pick  = rand_bits(2);
      flags = rand_bits(2);
      case (pick[1:0])
        2'd0:    size = BYTE;
        2'd1:
        begin
          size   = HWORD;
          adr[0] = 1'b0;
        end
        default:
        begin
          size     = WORD;
          adr[1:0] = 2'b00;
        end
      endcase
      send_req(make_req(adr, size, flags[0], flags[1], 1'b0, 1'b0));
    end
    // Overlap read takes region 0 attributes
    send_req(make_req(32'h0000_1900, WORD, 1'b0, 1'b0, 1'b0, 1'b0));
    compare_bit("bus_o.cacheable", bus_o.cacheable, 1'b1);
  endtask

  task automatic test_misaligned();
    send_req(make_req(32'h0000_1001, HWORD, 1'b0, 1'b0, 1'b0, 1'b0));
    send_req(make_req(32'h0000_1002, WORD, 1'b0, 1'b0, 1'b0, 1'b0));
    send_req(make_req(32'h0000_5003, WORD, 1'b1, 1'b0, 1'b0, 1'b0));
    send_req(make_req(32'h0000_1000, DWORD, 1'b0, 1'b0, 1'b0, 1'b0));
    send_req(make_req(32'h8000_0000, DWORD, 1'b1, 1'b1, 1'b0, 1'b0));
  endtask

  task automatic test_permission();
    send_req(make_req(32'h0000_1100, WORD, 1'b1, 1'b0, 1'b0, 1'b0));
    send_req(make_req(32'h0000_8000, BYTE, 1'b0, 1'b0, 1'b0, 1'b0));
    // Cache maintenance ignores alignment and rights
    send_req(make_req(32'h0000_1003, WORD, 1'b1, 1'b0, 1'b1, 1'b0));
    compare_bit("bus_o.cm_clean", bus_o.cm_clean, 1'b1);
    send_req(make_req(32'h0000_1101, DWORD, 1'b0, 1'b0, 1'b0, 1'b1));
    compare_bit("bus_o.cm_invalidate", bus_o.cm_invalidate, 1'b1);
    send_req(make_req(32'h0000_9000, WORD, 1'b0, 1'b0, 1'b1, 1'b0));
  endtask

  task automatic test_pipeline();
    cpu_req_t seq [4];
    seq[0] = make_req(32'h0000_1004, WORD, 1'b0, 1'b0, 1'b0, 1'b0);
    seq[1] = make_req(32'h0000_1006, HWORD, 1'b0, 1'b1, 1'b0, 1'b0);
    seq[2] = make_req(32'h0000_2001, BYTE, 1'b1, 1'b0, 1'b0, 1'b0);
    seq[3] = make_req(32'h0000_4000, WORD, 1'b0, 1'b0, 1'b0, 1'b0);
    // Back to back requests give one result per cycle
    for (int i = 0; i < 6; i++)
    begin
      @(negedge clk_i);
      if (i >= 2)
        check_result(seq[i-2]);
      req_i = (i < 4);
      if (i < 4)
        cpu_req_i = seq[i];
    end
    @(negedge clk_i);
    check_idle();
    // Stall with two requests in flight
    req_i     = 1'b1;
    cpu_req_i = seq[0];
    @(negedge clk_i);
    cpu_req_i = seq[1];
    @(negedge clk_i);
    check_result(seq[0]);
    req_i     = 1'b0;
    cpu_req_i = seq[3];
    stall_i   = 1'b1;
    repeat (3)
    begin
      @(negedge clk_i);
      check_result(seq[0]);
    end
    stall_i = 1'b0;
    @(negedge clk_i);
    check_result(seq[1]);
    @(negedge clk_i);
    check_idle();
    // Flush under stall drops both stages
    req_i     = 1'b1;
    cpu_req_i = seq[2];
    @(negedge clk_i);
    cpu_req_i = seq[3];
    @(negedge clk_i);
    check_result(seq[2]);
    req_i   = 1'b0;
    stall_i = 1'b1;
    flush_i = 1'b1;
    @(negedge clk_i);
    stall_i = 1'b0;
    flush_i = 1'b0;
    repeat (3)
    begin
      check_idle();
      @(negedge clk_i);
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial
  begin
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    stall_i      = 1'b0;
    flush_i      = 1'b0;
    req_i        = 1'b0;
    cfg_we_i     = 1'b0;
    cpu_req_i    = '0;
    cfg_idx_i    = '0;
    cfg_region_i = '0;
    for (int k = 0; k < NUM_REGIONS; k++)
      ref_regions[k] = '0;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    test_reset_state();
    test_random_access();
    test_misaligned();
    test_permission();
    test_pipeline();
    $display("Checks done, %0d errors", err_count);
    if (err_count == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
biu_pkg.sv
mem_xlate_stage.sv
pma_regs.sv
pma_check.sv
biu_issue.sv
mem_access_top.sv
tb_mem_access.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass or fail from the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module tb_mem_access -f sources.f -Mdir obj_dir \
  && ./obj_dir/Vtb_mem_access > sim.log 2>&1 \
  || { echo "Build or run error"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "Simulation passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
